/* bench/core_stim.txt */
// one 32-bit hex word per entry, loaded with $readmemh
// @00: prog_len wb_count br_count prog_base wb_base br_base; then program, (rd data), (pc taken target)
@00
00000015 0000000e 00000003 00000010 00000040 00000060
// program, entry prog_base + pc/4
@10
7f300093 // 00 addi x1, x0, 0x7f3
ff000113 // 04 addi x2, x0, -16
002081b3 // 08 add  x3, x1, x2
40118233 // 0c sub  x4, x3, x1
0021f2b3 // 10 and  x5, x3, x2
0012e333 // 14 or   x6, x5, x1
002343b3 // 18 xor  x7, x6, x2
12345437 // 1c lui  x8, 0x12345
67840413 // 20 addi x8, x8, 0x678
00108013 // 24 addi x0, x1, 1
001004b3 // 28 add  x9, x0, x1
00109463 // 2c bne  x1, x1, +8
00100513 // 30 addi x10, x0, 1
00220663 // 34 beq  x4, x2, +12
11100593 // 38 addi x11, x0, 0x111 (wrong path)
22200613 // 3c addi x12, x0, 0x222 (wrong path)
00c006ef // 40 jal  x13, +12
33300713 // 44 addi x14, x0, 0x333 (wrong path)
44400793 // 48 addi x15, x0, 0x444 (wrong path)
00868833 // 4c add  x16, x13, x8
40d808b3 // 50 sub  x17, x16, x13
// writebacks in retire order: rd data
@40
00000001 000007f3
00000002 fffffff0
00000003 000007e3
00000004 fffffff0
00000005 000007e0
00000006 000007f3
00000007 fffff803
00000008 12345000
00000008 12345678
00000009 000007f3
0000000a 00000001
0000000d 00000044
00000010 123456bc
00000011 12345678
// branch reports: pc taken target
@60
0000002c 00000000 00000034
00000034 00000001 00000040
00000040 00000001 0000004c

/* list.f */
+incdir+bench
source/core_pkg.sv
source/inst_decoder.sv
source/stage_reg.sv
source/reg_file.sv
source/operand_fwd.sv
source/exec_unit.sv
source/core_top.sv
bench/core_tb.sv

/* run.sh */
#!/bin/sh
# build the core testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f list.f --top-module core_tb -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "core_tb passed" ||
{ echo "core_tb failed"; exit 1; }

/* bench/core_checks.svh */
`ifndef CORE_CHECKS_SVH
`define CORE_CHECKS_SVH

// expects check_count and error_count in the including module

task automatic compare_wb(
    input core_pkg::reg_idx_t exp_rd,
    input core_pkg::reg_idx_t act_rd,
    input core_pkg::word_t    exp_data,
    input core_pkg::word_t    act_data
);
    check_count++;
    if (act_rd !== exp_rd) begin
        $display("MISMATCH wb_rd_o: expected 0x%h, actual 0x%h", exp_rd, act_rd);
        error_count++;
    end
    if (act_data !== exp_data) begin
        $display("MISMATCH wb_data_o: expected 0x%h, actual 0x%h", exp_data, act_data);
        error_count++;
    end
endtask

// report fields plus the redirect that a taken one must raise in the same cycle
task automatic compare_br(
    input core_pkg::addr_t exp_pc,
    input core_pkg::addr_t act_pc,
    input logic            exp_taken,
    input logic            act_taken,
    input core_pkg::addr_t exp_target,
    input core_pkg::addr_t act_target,
    input logic            act_redirect,
    input core_pkg::addr_t act_redirect_pc
);
    check_count++;
    if (act_pc !== exp_pc) begin
        $display("MISMATCH br_pc_o: expected 0x%h, actual 0x%h", exp_pc, act_pc);
        error_count++;
    end
    if (act_taken !== exp_taken) begin
        $display("MISMATCH br_taken_o: expected 0x%h, actual 0x%h", exp_taken, act_taken);
        error_count++;
    end
    if (act_target !== exp_target) begin
        $display("MISMATCH br_target_o: expected 0x%h, actual 0x%h", exp_target, act_target);
        error_count++;
    end
    if (act_redirect !== exp_taken) begin
        $display("MISMATCH redirect_o: expected 0x%h, actual 0x%h", exp_taken, act_redirect);
        error_count++;
    end else if (exp_taken && act_redirect_pc !== exp_target) begin
        $display("MISMATCH redirect_pc_o: expected 0x%h, actual 0x%h",
                 exp_target, act_redirect_pc);
        error_count++;
    end
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* bench/core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb;

    localparam int STIM_WORDS   = 256;
    localparam int RUN_LIMIT    = 400;
    localparam int DRAIN_CYCLES = 8;

    logic               clk;
    logic               rst_n_i;
    logic               inst_valid_i;
    core_pkg::addr_t    inst_pc_i;
    core_pkg::inst_t    inst_i;
    logic               redirect_o;
    core_pkg::addr_t    redirect_pc_o;
    logic               wb_valid_o;
    core_pkg::reg_idx_t wb_rd_o;
    core_pkg::word_t    wb_data_o;
    logic               br_valid_o;
    core_pkg::addr_t    br_pc_o;
    logic               br_taken_o;
    core_pkg::addr_t    br_target_o;

    logic [31:0] stim [STIM_WORDS];
    int prog_len;
    int wb_count;
    int br_count;
    int prog_base;
    int wb_base;
    int br_base;

    int check_count;
    int error_count;
    int test_count;
    logic timed_out;
    logic [31:0] rng_state;

    // progress of the current run
    int wb_seen;
    int br_seen;
    int redirect_seen;
    core_pkg::addr_t fetch_pc;

    `include "core_checks.svh"

    core_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_pc_i     (inst_pc_i),
        .inst_i        (inst_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .br_valid_o    (br_valid_o),
        .br_pc_o       (br_pc_o),
        .br_taken_o    (br_taken_o),
        .br_target_o   (br_target_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] stim_word(input int addr);
        return stim[addr[7:0]];
    endfunction

    task automatic apply_reset();
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_count++;
        if (redirect_o !== 1'b0 || wb_valid_o !== 1'b0 || br_valid_o !== 1'b0) begin
            $display("ERROR: output strobes are not low after reset");
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////
    task automatic check_outputs();
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        logic [31:0] exp_c;
        if (wb_valid_o === 1'b1) begin
            if (wb_seen < wb_count) begin
                exp_a = stim_word(wb_base + 2 * wb_seen);
                exp_b = stim_word(wb_base + 2 * wb_seen + 1);
                compare_wb(exp_a[4:0], wb_rd_o, exp_b, wb_data_o);
            end else begin
                $display("ERROR: unexpected writeback to x%0d with data 0x%h", wb_rd_o, wb_data_o);
                error_count++;
            end
            wb_seen++;
        end
        if (br_valid_o === 1'b1) begin
            if (br_seen < br_count) begin
                exp_a = stim_word(br_base + 3 * br_seen);
                exp_b = stim_word(br_base + 3 * br_seen + 1);
                exp_c = stim_word(br_base + 3 * br_seen + 2);
                compare_br(exp_a, br_pc_o, exp_b[0], br_taken_o, exp_c, br_target_o,
                           redirect_o, redirect_pc_o);
            end else begin
                $display("ERROR: unexpected branch report for pc 0x%h", br_pc_o);
                error_count++;
            end
            br_seen++;
        end else if (redirect_o !== 1'b0) begin
            $display("ERROR: redirect to 0x%h without a branch report", redirect_pc_o);
            error_count++;
        end
        if (redirect_o === 1'b1) begin
            redirect_seen++;
        end
    endtask

    //////////////////////////////////////////////////
    // instruction feeder
    //////////////////////////////////////////////////
    task automatic drive_inputs(input logic use_gaps);
        int word_idx;
        logic send;
        word_idx  = int'(fetch_pc >> 2);
        rng_state = xorshift32(rng_state);
        send      = !use_gaps || (rng_state[2:0] < 3'd5);
        if (redirect_o === 1'b1) begin
            // next edge is still inside the flush window
            fetch_pc     = redirect_pc_o;
            inst_valid_i = 1'b0;
        end else if (send && word_idx < prog_len) begin
            inst_valid_i = 1'b1;
            inst_pc_i    = fetch_pc;
            inst_i       = stim_word(prog_base + word_idx);
            fetch_pc     = fetch_pc + 32'd4;
        end else begin
            inst_valid_i = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input logic use_gaps);
        int cycles;
        int drain;
        int errors_before;
        logic finished;
        errors_before = error_count;
        wb_seen       = 0;
        br_seen       = 0;
        redirect_seen = 0;
        fetch_pc      = '0;
        cycles        = 0;
        drain         = 0;
        finished      = 1'b0;
        apply_reset();
        while (!finished && !timed_out) begin
            check_outputs();
            drive_inputs(use_gaps);
            if (wb_seen >= wb_count && br_seen >= br_count
                && int'(fetch_pc >> 2) >= prog_len) begin
                drain++;
            end
            finished = (drain >= DRAIN_CYCLES);
            cycles++;
            if (!finished && cycles >= RUN_LIMIT) begin
                $display("ERROR: %s did not finish within %0d cycles (%0d of %0d writebacks seen)",
                         name, RUN_LIMIT, wb_seen, wb_count);
                error_count++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        test_count++;
        $display("%s: %0d/%0d writebacks, %0d/%0d reports, %0d redirects, %0d errors",
                 name, wb_seen, wb_count, br_seen, br_count, redirect_seen,
                 error_count - errors_before);
    endtask

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_pc_i    = '0;
        inst_i       = '0;
        check_count  = 0;
        error_count  = 0;
        test_count   = 0;
        timed_out    = 1'b0;
        rng_state    = 32'hc663;
        $readmemh("bench/core_stim.txt", stim);
        prog_len  = int'(stim_word(0));
        wb_count  = int'(stim_word(1));
        br_count  = int'(stim_word(2));
        prog_base = int'(stim_word(3));
        wb_base   = int'(stim_word(4));
        br_base   = int'(stim_word(5));

        run_test("sequential feed", 1'b0);
        if (!timed_out) begin
            run_test("random gaps", 1'b1);
        end

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (timed_out || error_count != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input wire                     clk,
    input wire                     rst_n_i,

    input wire                     inst_valid_i,
    input wire core_pkg::addr_t    inst_pc_i,
    input wire core_pkg::inst_t    inst_i,

    output logic                   redirect_o,
    output core_pkg::addr_t        redirect_pc_o,

    output logic                   wb_valid_o,
    output core_pkg::reg_idx_t     wb_rd_o,
    output core_pkg::word_t        wb_data_o,

    output logic                   br_valid_o,
    output core_pkg::addr_t        br_pc_o,
    output logic                   br_taken_o,
    output core_pkg::addr_t        br_target_o
);

    // decode stage
    logic                 d_valid;
    core_pkg::addr_t      d_pc;
    core_pkg::inst_t      d_inst;
    core_pkg::ctrl_t      d_ctrl;
    core_pkg::word_t      d_imm;
    core_pkg::word_t      rf_rdata1;
    core_pkg::word_t      rf_rdata2;
    core_pkg::word_t      d_op1;
    core_pkg::word_t      d_op2;
    core_pkg::dx_payload_t dx_in;

    // execute stage
    logic                 x_valid;
    core_pkg::dx_payload_t x_q;
    core_pkg::word_t      x_result;
    logic                 x_taken;
    core_pkg::addr_t      x_target;
    logic                 x_is_branch;
    logic                 x_redirect;
    core_pkg::xw_payload_t xw_in;

    // writeback stage
    logic                 w_valid;
    core_pkg::xw_payload_t w_q;

    //////////////////////////////////////////////////
    // fetch -> decode
    //////////////////////////////////////////////////
    // drop wrong path for the two edges after a taken branch in x
    always_ff @(posedge clk) begin
        if (!rst_n_i || x_redirect || redirect_o) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            d_pc   <= inst_pc_i;
            d_inst <= inst_i;
        end
    end

    inst_decoder u_decoder (
        .inst_i (d_inst),
        .ctrl_o (d_ctrl),
        .imm_o  (d_imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .wen_i    (wb_valid_o),
        .waddr_i  (w_q.rd),
        .wdata_i  (w_q.result),
        .raddr1_i (d_ctrl.rs1),
        .raddr2_i (d_ctrl.rs2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    operand_fwd u_fwd (
        .rs1_i      (d_ctrl.rs1),
        .rs2_i      (d_ctrl.rs2),
        .rf_data1_i (rf_rdata1),
        .rf_data2_i (rf_rdata2),
        .x_valid_i  (x_valid),
        .x_wen_i    (x_q.ctrl.rf_wen),
        .x_rd_i     (x_q.ctrl.rd),
        .x_result_i (x_result),
        .w_valid_i  (w_valid),
        .w_wen_i    (w_q.rf_wen),
        .w_rd_i     (w_q.rd),
        .w_result_i (w_q.result),
        .op1_o      (d_op1),
        .op2_o      (d_op2)
    );

    always_comb begin
        dx_in.pc   = d_pc;
        dx_in.ctrl = d_ctrl;
        dx_in.imm  = d_imm;
        dx_in.op1  = d_op1;
        dx_in.op2  = d_op2;
    end

    stage_reg #(
        .payload_t (core_pkg::dx_payload_t)
    ) dx_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (1'b1),
        .flush_i (x_redirect),
        .valid_i (d_valid),
        .data_i  (dx_in),
        .valid_o (x_valid),
        .data_o  (x_q)
    );

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////
    exec_unit u_exec (
        .pc_i        (x_q.pc),
        .ctrl_i      (x_q.ctrl),
        .imm_i       (x_q.imm),
        .op1_i       (x_q.op1),
        .op2_i       (x_q.op2),
        .result_o    (x_result),
        .taken_o     (x_taken),
        .target_o    (x_target),
        .is_branch_o (x_is_branch)
    );

    // fall-through prediction, so every taken one redirects
    assign x_redirect = x_valid && x_taken;

    always_comb begin
        xw_in.pc     = x_q.pc;
        xw_in.rf_wen = x_q.ctrl.rf_wen;
        xw_in.rd     = x_q.ctrl.rd;
        xw_in.result = x_result;
    end

    stage_reg #(
        .payload_t (core_pkg::xw_payload_t)
    ) xw_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (1'b1),
        .flush_i (1'b0),
        .valid_i (x_valid),
        .data_i  (xw_in),
        .valid_o (w_valid),
        .data_o  (w_q)
    );

    //////////////////////////////////////////////////
    // redirect and branch report
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            redirect_o <= 1'b0;
            br_valid_o <= 1'b0;
        end else begin
            redirect_o <= x_redirect;
            br_valid_o <= x_valid && x_is_branch;
        end
    end

    // target is reported even when not taken
    always_ff @(posedge clk) begin
        redirect_pc_o <= x_target;
        br_pc_o       <= x_q.pc;
        br_taken_o    <= x_taken;
        br_target_o   <= x_target;
    end

    // writeback strobes skip x0
    assign wb_valid_o = w_valid && w_q.rf_wen && (w_q.rd != '0);
    assign wb_rd_o    = w_q.rd;
    assign wb_data_o  = w_q.result;

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input wire core_pkg::addr_t pc_i,
    input wire core_pkg::ctrl_t ctrl_i,
    input wire core_pkg::word_t imm_i,
    input wire core_pkg::word_t op1_i,
    input wire core_pkg::word_t op2_i,
    output core_pkg::word_t     result_o,
    output logic                taken_o,
    output core_pkg::addr_t     target_o,
    output logic                is_branch_o
);

    core_pkg::word_t alu_b;
    core_pkg::word_t alu_out;

    assign alu_b = (ctrl_i.op2_sel == core_pkg::OP2_IMM) ? imm_i : op2_i;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    always_comb begin
        case (ctrl_i.alu_op)
            core_pkg::ALU_ADD:    alu_out = op1_i + alu_b;
            core_pkg::ALU_SUB:    alu_out = op1_i - alu_b;
            core_pkg::ALU_AND:    alu_out = op1_i & alu_b;
            core_pkg::ALU_OR:     alu_out = op1_i | alu_b;
            core_pkg::ALU_XOR:    alu_out = op1_i ^ alu_b;
            core_pkg::ALU_PASS_B: alu_out = alu_b;
            default:              alu_out = '0;
        endcase
    end

    // jal writes the link address
    assign result_o = (ctrl_i.br_kind == core_pkg::BR_JUMP)
                    ? core_pkg::word_t'(pc_i + core_pkg::INST_BYTES)
                    : alu_out;

    //////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////
    always_comb begin
        case (ctrl_i.br_kind)
            core_pkg::BR_EQ:   taken_o = (op1_i == op2_i);
            core_pkg::BR_NE:   taken_o = (op1_i != op2_i);
            core_pkg::BR_JUMP: taken_o = 1'b1;
            default:           taken_o = 1'b0;
        endcase
    end

    // pc relative for both b and j formats
    assign target_o    = pc_i + imm_i;
    assign is_branch_o = (ctrl_i.br_kind != core_pkg::BR_NONE);

endmodule

`default_nettype wire

/* source/operand_fwd.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_fwd (
    input wire core_pkg::reg_idx_t rs1_i,
    input wire core_pkg::reg_idx_t rs2_i,
    input wire core_pkg::word_t    rf_data1_i,
    input wire core_pkg::word_t    rf_data2_i,

    input wire                     x_valid_i,
    input wire                     x_wen_i,
    input wire core_pkg::reg_idx_t x_rd_i,
    input wire core_pkg::word_t    x_result_i,

    input wire                     w_valid_i,
    input wire                     w_wen_i,
    input wire core_pkg::reg_idx_t w_rd_i,
    input wire core_pkg::word_t    w_result_i,

    output core_pkg::word_t        op1_o,
    output core_pkg::word_t        op2_o
);

    logic x_fwd_en;
    logic w_fwd_en;

    assign x_fwd_en = x_valid_i && x_wen_i && (x_rd_i != '0);
    assign w_fwd_en = w_valid_i && w_wen_i && (w_rd_i != '0);

    // youngest producer wins
    function automatic core_pkg::word_t select_src(
        input core_pkg::reg_idx_t rs,
        input core_pkg::word_t    rf_val
    );
        core_pkg::word_t val;
        val = rf_val;
        if (x_fwd_en && rs == x_rd_i) begin
            val = x_result_i;
        end else if (w_fwd_en && rs == w_rd_i) begin
            val = w_result_i;
        end
        return val;
    endfunction

    always_comb begin
        op1_o = select_src(rs1_i, rf_data1_i);
        op2_o = select_src(rs2_i, rf_data2_i);
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input wire                     clk,
    input wire                     wen_i,
    input wire core_pkg::reg_idx_t waddr_i,
    input wire core_pkg::word_t    wdata_i,
    input wire core_pkg::reg_idx_t raddr1_i,
    input wire core_pkg::reg_idx_t raddr2_i,
    output core_pkg::word_t        rdata1_o,
    output core_pkg::word_t        rdata2_o
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 always reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* source/stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input wire           clk,
    input wire           rst_n_i,
    input wire           load_i,
    input wire           flush_i,
    input wire           valid_i,
    input wire payload_t data_i,
    output logic         valid_o,
    output payload_t     data_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    // payload qualified by valid_o
    always_ff @(posedge clk) begin
        if (load_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input wire core_pkg::inst_t inst_i,
    output core_pkg::ctrl_t     ctrl_o,
    output core_pkg::word_t     imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    core_pkg::word_t imm_i_type;
    core_pkg::word_t imm_u_type;
    core_pkg::word_t imm_b_type;
    core_pkg::word_t imm_j_type;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        // unknown encodings fall through as a harmless nop
        ctrl_o.alu_op  = core_pkg::ALU_ADD;
        ctrl_o.br_kind = core_pkg::BR_NONE;
        ctrl_o.op2_sel = core_pkg::OP2_RS2;
        ctrl_o.rf_wen  = 1'b0;
        ctrl_o.rd      = inst_i[11:7];
        ctrl_o.rs1     = inst_i[19:15];
        ctrl_o.rs2     = inst_i[24:20];
        imm_o          = '0;

        case (opcode)
            core_pkg::OPC_OP: begin
                ctrl_o.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = core_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = core_pkg::ALU_SUB;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = core_pkg::ALU_XOR;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = core_pkg::ALU_OR;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = core_pkg::ALU_AND;
                    default:              ctrl_o.rf_wen = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                // addi only
                ctrl_o.op2_sel = core_pkg::OP2_IMM;
                ctrl_o.rf_wen  = (funct3 == 3'b000);
                imm_o          = imm_i_type;
            end
            core_pkg::OPC_LUI: begin
                ctrl_o.alu_op  = core_pkg::ALU_PASS_B;
                ctrl_o.op2_sel = core_pkg::OP2_IMM;
                ctrl_o.rf_wen  = 1'b1;
                imm_o          = imm_u_type;
            end
            core_pkg::OPC_BRANCH: begin
                imm_o = imm_b_type;
                case (funct3)
                    3'b000:  ctrl_o.br_kind = core_pkg::BR_EQ;
                    3'b001:  ctrl_o.br_kind = core_pkg::BR_NE;
                    default: ctrl_o.br_kind = core_pkg::BR_NONE;
                endcase
            end
            core_pkg::OPC_JAL: begin
                ctrl_o.br_kind = core_pkg::BR_JUMP;
                ctrl_o.rf_wen  = 1'b1;
                imm_o          = imm_j_type;
            end
            default: begin
                ctrl_o.rf_wen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int INST_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } br_kind_t;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_t;

    typedef struct packed {
        alu_op_t  alu_op;
        br_kind_t br_kind;
        op2_sel_t op2_sel;
        logic     rf_wen;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } ctrl_t;

    // decode -> execute
    typedef struct packed {
        addr_t pc;
        ctrl_t ctrl;
        word_t imm;
        word_t op1;
        word_t op2;
    } dx_payload_t;

    // execute -> writeback
    typedef struct packed {
        addr_t    pc;
        logic     rf_wen;
        reg_idx_t rd;
        word_t    result;
    } xw_payload_t;

endpackage

`default_nettype wire
